/* hdl/wb_pkg.sv */
package wb_pkg;

   // condition applied to the EIP load or the GPR2 load
   typedef enum logic [1:0] {
      cond_always = 2'd0,
      cond_jne    = 2'd1,
      cond_jnbe   = 2'd2,
      cond_cmovc  = 2'd3
   } wb_cond_e;

   // source of the data1 write port
   typedef enum logic [2:0] {
      d1_result_a   = 3'd0,
      d1_push_flags = 3'd1,
      d1_temp_neip  = 3'd2,
      d1_temp_ncs   = 3'd3,
      d1_cmps_latch = 3'd4
   } wb_data1_sel_e;

   // flag bit positions
   localparam int CF_BIT = 0;
   localparam int ZF_BIT = 6;

   // only the reserved bit 1 is set out of reset
   localparam logic [31:0] FLAGS_RESET = 32'h0000_0002;

   // widest flags register, the mask field is sized for it
   localparam int FLAGS_MAX_W = 32;

   typedef struct packed {
      wb_cond_e               cond;
      wb_data1_sel_e          data1_sel;
      logic                   ld_gpr3;
      logic                   ld_seg;
      logic                   ld_mm;
      logic                   ld_flags;
      logic                   ld_eip;
      logic                   ld_cs;
      logic                   pop_flags;
      logic [FLAGS_MAX_W-1:0] flags_affected;
      logic                   save_neip;
      logic                   save_ncs;
      logic                   use_temp_neip;
      logic                   use_temp_ncs;
      logic                   is_cmps_first;
      logic                   is_cmps_second;
      logic                   is_halt;
      logic                   mm_mem;
   } wb_ctrl_t;

   typedef struct packed {
      logic [2:0]  dr1;
      logic [2:0]  dr2;
      logic [2:0]  dr3;
      logic [31:0] data1;
      logic [31:0] data2;
      logic [31:0] data3;
      logic        ld_gpr1;
      logic        ld_gpr2;
      logic        ld_gpr3;
      logic [1:0]  datasize;
   } wb_gpr_wr_t;

   typedef struct packed {
      logic gpr1;
      logic gpr2;
      logic gpr3;
      logic seg;
      logic mm;
      logic dcache_write;
   } wb_dep_t;

   typedef struct packed {
      logic [63:0] data;
      logic [31:0] addr;
      logic        write;
   } wb_dcache_wr_t;

endpackage

/* hdl/flags_wb.sv */
`timescale 1ns/1ps

module flags_wb
   import wb_pkg::*;
#(
   parameter int FLAGS_W = 32
) (
   input  logic               CLK,
   input  logic               rst_n,
   input  logic               advance,
   input  logic               ld_flags,
   input  logic               pop_flags,
   input  logic [FLAGS_W-1:0] flags_affected,
   input  logic [FLAGS_W-1:0] flags_in,
   input  logic [31:0]        result_a,
   output logic [FLAGS_W-1:0] cur_flags,
   output logic [FLAGS_W-1:0] new_flags
);

   logic [FLAGS_W-1:0] merged;

   // bits under the mask come from execute, the rest are kept
   assign merged = (cur_flags & ~flags_affected) | (flags_in & flags_affected);

   always_comb begin
      if (pop_flags) begin
         // popf takes the popped word as a whole
         new_flags = result_a[FLAGS_W-1:0];
      end else begin
         new_flags = merged;
      end
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         cur_flags <= FLAGS_RESET[FLAGS_W-1:0];
      end else if (advance && ld_flags) begin
         cur_flags <= new_flags;
      end
   end

endmodule

/* hdl/operand_select_wb.sv */
`timescale 1ns/1ps

module operand_select_wb
   import wb_pkg::*;
#(
   parameter int FLAGS_W = 32
) (
   input  logic               CLK,
   input  logic               rst_n,
   input  logic               advance,
   input  wb_ctrl_t           ctrl,
   input  logic [31:0]        result_a,
   input  logic [31:0]        neip,
   input  logic [15:0]        ncs,
   input  logic [FLAGS_W-1:0] cur_flags,
   output logic [31:0]        data1,
   output logic [31:0]        final_eip,
   output logic [15:0]        final_cs
);

   logic [31:0] temp_neip;
   logic [15:0] temp_ncs;
   logic [31:0] cmps_latch;
   logic [31:0] flags_ext;

   // pushf stores the flags zero extended to a full word
   always_comb begin
      flags_ext = '0;
      flags_ext[FLAGS_W-1:0] = cur_flags;
   end

   always_comb begin
      case (ctrl.data1_sel)
         d1_push_flags: data1 = flags_ext;
         d1_temp_neip:  data1 = temp_neip;
         d1_temp_ncs:   data1 = {16'h0000, temp_ncs};
         d1_cmps_latch: data1 = cmps_latch;
         default:       data1 = result_a;
      endcase
   end

   // far transfers write the target from the saved pair
   assign final_eip = ctrl.use_temp_neip ? temp_neip : neip;
   assign final_cs  = ctrl.use_temp_ncs ? temp_ncs : ncs;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         temp_neip  <= '0;
         temp_ncs   <= '0;
         cmps_latch <= '0;
      end else if (advance) begin
         if (ctrl.save_neip) begin
            temp_neip <= neip;
         end
         if (ctrl.save_ncs) begin
            temp_ncs <= ncs;
         end
         // first cmps uop holds its operand for the second
         if (ctrl.is_cmps_first) begin
            cmps_latch <= result_a;
         end
      end
   end

endmodule

/* hdl/branch_cond_wb.sv */
`timescale 1ns/1ps

module branch_cond_wb
   import wb_pkg::*;
(
   input  wb_cond_e          cond,
   input  logic              ld_eip_req,
   input  logic              ex_ld_gpr2,
   input  logic [ZF_BIT:0]   cur_flags,
   output logic              take_eip,
   output logic              take_gpr2
);

   logic cf;
   logic zf;

   assign cf = cur_flags[CF_BIT];
   assign zf = cur_flags[ZF_BIT];

   always_comb begin
      case (cond)
         cond_jne:  take_eip = ld_eip_req & ~zf;
         // above means neither carry nor zero
         cond_jnbe: take_eip = ld_eip_req & ~cf & ~zf;
         default:   take_eip = ld_eip_req;
      endcase
   end

   // cmovc only writes its destination on carry
   always_comb begin
      if (cond == cond_cmovc) begin
         take_gpr2 = ex_ld_gpr2 & cf;
      end else begin
         take_gpr2 = ex_ld_gpr2;
      end
   end

endmodule

/* hdl/repne_halt_wb.sv */
`timescale 1ns/1ps

module repne_halt_wb
   import wb_pkg::*;
(
   input  logic            wb_v,
   input  logic            is_halt,
   input  logic            is_cmps_second,
   input  logic            repne,
   input  logic [ZF_BIT:0] cur_flags,
   input  logic [31:0]     result_c,
   output logic            halt_req,
   output logic            terminate,
   output logic [31:0]     count
);

   logic rep_cmps;
   logic stop_cond;

   // ecx after this iteration
   assign count = result_c - 32'd1;

   assign rep_cmps = wb_v & is_cmps_second & repne;

   // repne ends on a match or when the count runs out
   assign stop_cond = cur_flags[ZF_BIT] | (count == 32'd0);

   assign terminate = rep_cmps & stop_cond;

   assign halt_req = wb_v & is_halt;

endmodule

/* hdl/validate_signals_wb.sv */
`timescale 1ns/1ps

module validate_signals_wb
   import wb_pkg::*;
(
   input  logic     wb_v,
   input  wb_ctrl_t ctrl,
   input  logic     ex_ld_gpr1,
   input  logic     take_gpr2,
   input  logic     ex_dcache_write,
   input  logic     take_eip,
   input  logic     repne,
   input  logic     terminate,
   input  logic     write_ready,
   output logic     ld_gpr1,
   output logic     ld_gpr2,
   output logic     ld_gpr3,
   output logic     ld_seg,
   output logic     ld_mm,
   output logic     ld_flags,
   output logic     ld_eip,
   output logic     ld_cs,
   output logic     dcache_write,
   output logic     advance,
   output logic     stall
);

   logic rep_cmps;

   assign ld_gpr1      = wb_v & ex_ld_gpr1;
   assign ld_gpr2      = wb_v & take_gpr2;
   assign ld_gpr3      = wb_v & ctrl.ld_gpr3;
   assign ld_seg       = wb_v & ctrl.ld_seg;
   assign ld_mm        = wb_v & ctrl.ld_mm;
   assign ld_flags     = wb_v & ctrl.ld_flags;
   assign ld_cs        = wb_v & ctrl.ld_cs;
   assign dcache_write = wb_v & ex_dcache_write;

   // eip stays put each iteration so the string op is refetched
   assign rep_cmps = ctrl.is_cmps_second & repne;
   assign ld_eip   = wb_v & (rep_cmps ? terminate : take_eip);

   // hold the uop while the cache write port is busy
   assign stall   = wb_v & ex_dcache_write & ~write_ready;
   assign advance = wb_v & ~stall;

endmodule

/* hdl/writeback.sv */
`timescale 1ns/1ps

module writeback
   import wb_pkg::*;
#(
   parameter int FLAGS_W = 32
) (
   input  logic               CLK,
   input  logic               rst_n,
   input  logic               wb_v,
   input  wb_ctrl_t           wb_ctrl,
   input  logic [1:0]         datasize,
   input  logic               ex_ld_gpr1,
   input  logic               ex_ld_gpr2,
   input  logic               ex_dcache_write,
   input  logic               repne,
   input  logic [31:0]        neip,
   input  logic [15:0]        ncs,
   input  logic [31:0]        result_a,
   input  logic [31:0]        result_b,
   input  logic [31:0]        result_c,
   input  logic [FLAGS_W-1:0] flags_in,
   input  logic [63:0]        result_mm,
   input  logic [2:0]         dr1,
   input  logic [2:0]         dr2,
   input  logic [2:0]         dr3,
   input  logic [31:0]        address,
   input  logic               write_ready,
   output wb_gpr_wr_t         gpr_wr,
   output logic               ld_seg,
   output logic [63:0]        mm_data,
   output logic               ld_mm,
   output logic [31:0]        final_eip,
   output logic               ld_eip,
   output logic [15:0]        final_cs,
   output logic               ld_cs,
   output logic [FLAGS_W-1:0] final_flags,
   output logic               ld_flags,
   output wb_dcache_wr_t      dcache_wr,
   output wb_dep_t            dep,
   output logic               halt_all,
   output logic               repne_terminate,
   output logic               stall,
   output logic [FLAGS_W-1:0] flags_fwd,
   output logic [31:0]        count_fwd
);

   logic [FLAGS_W-1:0] cur_flags;
   logic [FLAGS_W-1:0] new_flags;
   logic [31:0]        data1;
   logic [31:0]        count;
   logic               take_eip;
   logic               take_gpr2;
   logic               terminate;
   logic               halt_req;
   logic               advance;
   logic               ld_gpr1;
   logic               ld_gpr2;
   logic               ld_gpr3;
   logic               dcache_write;

   flags_wb #(.FLAGS_W(FLAGS_W)) u_flags_wb (
      .CLK            (CLK),
      .rst_n          (rst_n),
      .advance        (advance),
      .ld_flags       (ld_flags),
      .pop_flags      (wb_ctrl.pop_flags),
      .flags_affected (wb_ctrl.flags_affected[FLAGS_W-1:0]),
      .flags_in       (flags_in),
      .result_a       (result_a),
      .cur_flags      (cur_flags),
      .new_flags      (new_flags)
   );

   operand_select_wb #(.FLAGS_W(FLAGS_W)) u_operand_select_wb (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .advance   (advance),
      .ctrl      (wb_ctrl),
      .result_a  (result_a),
      .neip      (neip),
      .ncs       (ncs),
      .cur_flags (cur_flags),
      .data1     (data1),
      .final_eip (final_eip),
      .final_cs  (final_cs)
   );

   branch_cond_wb u_branch_cond_wb (
      .cond       (wb_ctrl.cond),
      .ld_eip_req (wb_ctrl.ld_eip),
      .ex_ld_gpr2 (ex_ld_gpr2),
      .cur_flags  (cur_flags[ZF_BIT:0]),
      .take_eip   (take_eip),
      .take_gpr2  (take_gpr2)
   );

   repne_halt_wb u_repne_halt_wb (
      .wb_v           (wb_v),
      .is_halt        (wb_ctrl.is_halt),
      .is_cmps_second (wb_ctrl.is_cmps_second),
      .repne          (repne),
      .cur_flags      (cur_flags[ZF_BIT:0]),
      .result_c       (result_c),
      .halt_req       (halt_req),
      .terminate      (terminate),
      .count          (count)
   );

   validate_signals_wb u_validate_signals_wb (
      .wb_v            (wb_v),
      .ctrl            (wb_ctrl),
      .ex_ld_gpr1      (ex_ld_gpr1),
      .take_gpr2       (take_gpr2),
      .ex_dcache_write (ex_dcache_write),
      .take_eip        (take_eip),
      .repne           (repne),
      .terminate       (terminate),
      .write_ready     (write_ready),
      .ld_gpr1         (ld_gpr1),
      .ld_gpr2         (ld_gpr2),
      .ld_gpr3         (ld_gpr3),
      .ld_seg          (ld_seg),
      .ld_mm           (ld_mm),
      .ld_flags        (ld_flags),
      .ld_eip          (ld_eip),
      .ld_cs           (ld_cs),
      .dcache_write    (dcache_write),
      .advance         (advance),
      .stall           (stall)
   );

   // gpr file write port
   assign gpr_wr.dr1      = dr1;
   assign gpr_wr.dr2      = dr2;
   assign gpr_wr.dr3      = dr3;
   assign gpr_wr.data1    = data1;
   assign gpr_wr.data2    = result_b;
   assign gpr_wr.data3    = result_c;
   assign gpr_wr.ld_gpr1  = ld_gpr1;
   assign gpr_wr.ld_gpr2  = ld_gpr2;
   assign gpr_wr.ld_gpr3  = ld_gpr3;
   assign gpr_wr.datasize = datasize;

   assign mm_data = result_mm;

   // mmx stores take the full 64 bits, everything else is a word
   assign dcache_wr.data  = wb_ctrl.mm_mem ? result_mm : {32'h0000_0000, data1};
   assign dcache_wr.addr  = address;
   assign dcache_wr.write = dcache_write;

   // valid bits for the dependency check upstream
   assign dep.gpr1         = ld_gpr1;
   assign dep.gpr2         = ld_gpr2;
   assign dep.gpr3         = ld_gpr3;
   assign dep.seg          = ld_seg;
   assign dep.mm           = ld_mm;
   assign dep.dcache_write = dcache_write;

   assign final_flags     = new_flags;
   assign halt_all        = halt_req;
   assign repne_terminate = terminate;

   assign flags_fwd = cur_flags;
   assign count_fwd = count;

endmodule

/* testbench/writeback_sva.sv */
`timescale 1ns/1ps

module writeback_sva
   import wb_pkg::*;
#(
   parameter int FLAGS_W = 32
) (
   input logic               CLK,
   input logic               rst_n,
   input logic               wb_v,
   input logic               stall,
   input logic               halt_all,
   input logic               repne_terminate,
   input wb_gpr_wr_t         gpr_wr,
   input logic               ld_seg,
   input logic               ld_mm,
   input logic               ld_flags,
   input logic               ld_eip,
   input logic               ld_cs,
   input wb_dcache_wr_t      dcache_wr,
   input wb_dep_t            dep,
   input logic [FLAGS_W-1:0] flags_fwd
);

   logic any_enable;

   assign any_enable = gpr_wr.ld_gpr1 | gpr_wr.ld_gpr2 | gpr_wr.ld_gpr3 | ld_seg | ld_mm
                     | ld_flags | ld_eip | ld_cs | dcache_wr.write | (|dep)
                     | halt_all | repne_terminate | stall;

   stall_needs_write: assert property (@(posedge CLK) disable iff (!rst_n)
      stall |-> dcache_wr.write)
      else $error("stall raised without a cache write");

   quiet_when_invalid: assert property (@(posedge CLK) disable iff (!rst_n)
      !wb_v |-> !any_enable)
      else $error("enable or status high with wb_v low");

   halt_needs_valid: assert property (@(posedge CLK) disable iff (!rst_n)
      halt_all |-> wb_v)
      else $error("halt_all without a valid uop");

   // a stalled uop must not touch the flags register
   flags_hold_on_stall: assert property (@(posedge CLK) disable iff (!rst_n)
      stall |=> $stable(flags_fwd))
      else $error("flags changed during a stall");

endmodule

bind writeback writeback_sva #(.FLAGS_W(FLAGS_W)) u_writeback_sva (
   .CLK             (CLK),
   .rst_n           (rst_n),
   .wb_v            (wb_v),
   .stall           (stall),
   .halt_all        (halt_all),
   .repne_terminate (repne_terminate),
   .gpr_wr          (gpr_wr),
   .ld_seg          (ld_seg),
   .ld_mm           (ld_mm),
   .ld_flags        (ld_flags),
   .ld_eip          (ld_eip),
   .ld_cs           (ld_cs),
   .dcache_wr       (dcache_wr),
   .dep             (dep),
   .flags_fwd       (flags_fwd)
);

/* testbench/writeback_tb.sv */
`timescale 1ns/1ps

module writeback_tb
   import wb_pkg::*;
();

   localparam int FLAGS_W = 32;

   // bit order {gpr1, gpr2, gpr3, seg, mm, flags, eip, cs, dcache}
   localparam logic [8:0] EN_GPR1  = 9'h100;
   localparam logic [8:0] EN_GPR2  = 9'h080;
   localparam logic [8:0] EN_GPR3  = 9'h040;
   localparam logic [8:0] EN_SEG   = 9'h020;
   localparam logic [8:0] EN_MM    = 9'h010;
   localparam logic [8:0] EN_FLAGS = 9'h008;
   localparam logic [8:0] EN_EIP   = 9'h004;
   localparam logic [8:0] EN_CS    = 9'h002;
   localparam logic [8:0] EN_DC    = 9'h001;

   typedef struct {
      string       name;
      logic        wb_v;
      wb_ctrl_t    ctrl;
      logic        ex_ld_gpr1;
      logic        ex_ld_gpr2;
      logic        ex_dcache_write;
      logic        repne;
      int          hold;
      logic [31:0] result_a;
      logic [31:0] result_b;
      logic [31:0] result_c;
      logic [31:0] neip;
      logic [15:0] ncs;
      logic [31:0] flags_in;
      logic [63:0] result_mm;
      logic [31:0] address;
      logic [8:0]  dr;
      logic [1:0]  datasize;
      logic [8:0]  exp_en;
      logic        exp_halt;
      logic        exp_term;
      logic [31:0] exp_flags;
      logic [31:0] exp_fwd;
      logic [31:0] exp_data1;
      logic [31:0] exp_eip;
      logic [15:0] exp_cs;
      logic [31:0] exp_count;
      logic [63:0] exp_dc_data;
   } entry_t;

   logic               CLK;
   logic               rst_n;
   logic               wb_v;
   wb_ctrl_t           wb_ctrl;
   logic [1:0]         datasize;
   logic               ex_ld_gpr1;
   logic               ex_ld_gpr2;
   logic               ex_dcache_write;
   logic               repne;
   logic [31:0]        neip;
   logic [15:0]        ncs;
   logic [31:0]        result_a;
   logic [31:0]        result_b;
   logic [31:0]        result_c;
   logic [FLAGS_W-1:0] flags_in;
   logic [63:0]        result_mm;
   logic [2:0]         dr1;
   logic [2:0]         dr2;
   logic [2:0]         dr3;
   logic [31:0]        address;
   logic               write_ready;
   wb_gpr_wr_t         gpr_wr;
   logic               ld_seg;
   logic [63:0]        mm_data;
   logic               ld_mm;
   logic [31:0]        final_eip;
   logic               ld_eip;
   logic [15:0]        final_cs;
   logic               ld_cs;
   logic [FLAGS_W-1:0] final_flags;
   logic               ld_flags;
   wb_dcache_wr_t      dcache_wr;
   wb_dep_t            dep;
   logic               halt_all;
   logic               repne_terminate;
   logic               stall;
   logic [FLAGS_W-1:0] flags_fwd;
   logic [31:0]        count_fwd;

   entry_t      tests[$];
   logic [31:0] lfsr_state;
   logic [31:0] flags_now;
   int          error_count;
   int          pass_count;
   int          fail_count;
   logic        timed_out;

   writeback #(.FLAGS_W(FLAGS_W)) UUT (.*);

   always #2 CLK = ~CLK;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end else begin
         return s >> 1;
      end
   endfunction

   // one lfsr step per bit
   function automatic logic [31:0] random_word(input int nbits);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   // random data, no requests, expectations of an idle valid uop
   function automatic entry_t blank_entry(input string name);
      entry_t      e;
      logic [31:0] w;
      e.name            = name;
      e.wb_v            = 1'b1;
      e.ctrl            = '0;
      e.ex_ld_gpr1      = 1'b0;
      e.ex_ld_gpr2      = 1'b0;
      e.ex_dcache_write = 1'b0;
      e.repne           = 1'b0;
      e.hold            = 0;
      e.result_a        = random_word(32);
      e.result_b        = random_word(32);
      e.result_c        = random_word(32);
      e.neip            = random_word(32);
      w                 = random_word(16);
      e.ncs             = w[15:0];
      e.flags_in        = random_word(32);
      e.result_mm       = {random_word(32), random_word(32)};
      e.address         = random_word(32);
      w                 = random_word(9);
      e.dr              = w[8:0];
      w                 = random_word(2);
      e.datasize        = w[1:0];
      e.exp_en          = '0;
      e.exp_halt        = 1'b0;
      e.exp_term        = 1'b0;
      e.exp_flags       = flags_now;
      e.exp_fwd         = flags_now;
      e.exp_data1       = e.result_a;
      e.exp_eip         = e.neip;
      e.exp_cs          = e.ncs;
      e.exp_count       = e.result_c - 32'd1;
      e.exp_dc_data     = {32'h0000_0000, e.result_a};
      return e;
   endfunction

   task automatic build_table();
      entry_t      e;
      logic [31:0] saved_eip;
      logic [15:0] saved_cs;
      logic [31:0] saved_cmp;
      // count of one would end a repne, busy port would stall a valid uop
      e = blank_entry("invalid uop");
      e.wb_v = 1'b0;
      e.ctrl.ld_gpr3 = 1'b1;
      e.ctrl.ld_seg = 1'b1;
      e.ctrl.ld_mm = 1'b1;
      e.ctrl.ld_flags = 1'b1;
      e.ctrl.ld_eip = 1'b1;
      e.ctrl.ld_cs = 1'b1;
      e.ctrl.is_halt = 1'b1;
      e.ctrl.is_cmps_second = 1'b1;
      e.ex_ld_gpr1 = 1'b1;
      e.ex_ld_gpr2 = 1'b1;
      e.ex_dcache_write = 1'b1;
      e.repne = 1'b1;
      e.result_c = 32'd1;
      e.exp_count = 32'd0;
      e.hold = 1;
      tests.push_back(e);
      // set cf and zf through the mask
      e = blank_entry("flags merge");
      e.ctrl.ld_flags = 1'b1;
      e.ctrl.flags_affected = 32'h0000_0041;
      e.flags_in = 32'hffff_ffff;
      e.exp_en = EN_FLAGS;
      e.exp_flags = 32'h0000_0043;
      tests.push_back(e);
      flags_now = 32'h0000_0043;
      e = blank_entry("flags pop");
      e.ctrl.ld_flags = 1'b1;
      e.ctrl.pop_flags = 1'b1;
      e.result_a = 32'h0000_08d5;
      e.exp_data1 = 32'h0000_08d5;
      e.exp_dc_data = 64'h0000_08d5;
      e.exp_en = EN_FLAGS;
      e.exp_flags = 32'h0000_08d5;
      tests.push_back(e);
      flags_now = 32'h0000_08d5;
      e = blank_entry("jne with zf set");
      e.ctrl.cond = cond_jne;
      e.ctrl.ld_eip = 1'b1;
      tests.push_back(e);
      // leave cf alone so jnbe is decided by carry
      e = blank_entry("clear zf");
      e.ctrl.ld_flags = 1'b1;
      e.ctrl.flags_affected = 32'h0000_0040;
      e.flags_in = 32'h0000_0000;
      e.exp_en = EN_FLAGS;
      e.exp_flags = 32'h0000_0895;
      tests.push_back(e);
      flags_now = 32'h0000_0895;
      e = blank_entry("jnbe with cf set");
      e.ctrl.cond = cond_jnbe;
      e.ctrl.ld_eip = 1'b1;
      tests.push_back(e);
      e = blank_entry("cmovc with cf set");
      e.ctrl.cond = cond_cmovc;
      e.ctrl.ld_eip = 1'b1;
      e.ex_ld_gpr2 = 1'b1;
      e.exp_en = EN_GPR2 | EN_EIP;
      tests.push_back(e);
      e = blank_entry("clear cf and zf");
      e.ctrl.ld_flags = 1'b1;
      e.ctrl.flags_affected = 32'h0000_0041;
      e.flags_in = 32'h0000_0000;
      e.exp_en = EN_FLAGS;
      e.exp_flags = 32'h0000_0894;
      tests.push_back(e);
      flags_now = 32'h0000_0894;
      e = blank_entry("jne taken");
      e.ctrl.cond = cond_jne;
      e.ctrl.ld_eip = 1'b1;
      e.exp_en = EN_EIP;
      tests.push_back(e);
      e = blank_entry("jnbe taken");
      e.ctrl.cond = cond_jnbe;
      e.ctrl.ld_eip = 1'b1;
      e.exp_en = EN_EIP;
      tests.push_back(e);
      e = blank_entry("cmovc with cf clear");
      e.ctrl.cond = cond_cmovc;
      e.ex_ld_gpr2 = 1'b1;
      tests.push_back(e);
      e = blank_entry("save neip and ncs");
      e.ctrl.save_neip = 1'b1;
      e.ctrl.save_ncs = 1'b1;
      saved_eip = e.neip;
      saved_cs = e.ncs;
      tests.push_back(e);
      e = blank_entry("far transfer from temps");
      e.ctrl.use_temp_neip = 1'b1;
      e.ctrl.use_temp_ncs = 1'b1;
      e.ctrl.ld_eip = 1'b1;
      e.ctrl.ld_cs = 1'b1;
      e.ctrl.data1_sel = d1_temp_neip;
      e.exp_en = EN_EIP | EN_CS;
      e.exp_eip = saved_eip;
      e.exp_cs = saved_cs;
      e.exp_data1 = saved_eip;
      e.exp_dc_data = {32'h0000_0000, saved_eip};
      tests.push_back(e);
      e = blank_entry("cmps first");
      e.ctrl.is_cmps_first = 1'b1;
      e.ex_ld_gpr1 = 1'b1;
      e.exp_en = EN_GPR1;
      saved_cmp = e.result_a;
      tests.push_back(e);
      e = blank_entry("cmps latch select");
      e.ctrl.data1_sel = d1_cmps_latch;
      e.ex_ld_gpr1 = 1'b1;
      e.exp_en = EN_GPR1;
      e.exp_data1 = saved_cmp;
      e.exp_dc_data = {32'h0000_0000, saved_cmp};
      tests.push_back(e);
      // zf is clear here, so only the count decides
      e = blank_entry("repne count left");
      e.ctrl.is_cmps_second = 1'b1;
      e.ctrl.ld_eip = 1'b1;
      e.repne = 1'b1;
      e.result_c = 32'd5;
      e.exp_count = 32'd4;
      tests.push_back(e);
      e = blank_entry("repne count done");
      e.ctrl.is_cmps_second = 1'b1;
      e.ctrl.ld_eip = 1'b1;
      e.repne = 1'b1;
      e.result_c = 32'd1;
      e.exp_count = 32'd0;
      e.exp_term = 1'b1;
      e.exp_en = EN_EIP;
      tests.push_back(e);
      e = blank_entry("set zf");
      e.ctrl.ld_flags = 1'b1;
      e.ctrl.flags_affected = 32'h0000_0040;
      e.flags_in = 32'h0000_0040;
      e.exp_en = EN_FLAGS;
      e.exp_flags = 32'h0000_08d4;
      tests.push_back(e);
      flags_now = 32'h0000_08d4;
      e = blank_entry("repne match");
      e.ctrl.is_cmps_second = 1'b1;
      e.ctrl.ld_eip = 1'b1;
      e.repne = 1'b1;
      e.result_c = 32'd9;
      e.exp_count = 32'd8;
      e.exp_term = 1'b1;
      e.exp_en = EN_EIP;
      tests.push_back(e);
      e = blank_entry("gpr3 seg and mmx loads");
      e.ctrl.ld_gpr3 = 1'b1;
      e.ctrl.ld_seg = 1'b1;
      e.ctrl.ld_mm = 1'b1;
      e.exp_en = EN_GPR3 | EN_SEG | EN_MM;
      tests.push_back(e);
      e = blank_entry("halt");
      e.ctrl.is_halt = 1'b1;
      e.exp_halt = 1'b1;
      tests.push_back(e);
      // busy write port for three cycles, flags must hold
      e = blank_entry("stalled mmx store");
      e.ctrl.mm_mem = 1'b1;
      e.ctrl.ld_flags = 1'b1;
      e.ctrl.flags_affected = 32'h0000_0001;
      e.flags_in = 32'h0000_0001;
      e.ex_dcache_write = 1'b1;
      e.hold = 3;
      e.exp_en = EN_FLAGS | EN_DC;
      e.exp_flags = 32'h0000_08d5;
      e.exp_dc_data = e.result_mm;
      tests.push_back(e);
      flags_now = 32'h0000_08d5;
      e = blank_entry("word store");
      e.ex_dcache_write = 1'b1;
      e.exp_en = EN_DC;
      tests.push_back(e);
      e = blank_entry("idle after store");
      e.wb_v = 1'b0;
      tests.push_back(e);
   endtask

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_outputs(input entry_t e, input logic exp_stall);
      logic [8:0] got_en;
      got_en = {gpr_wr.ld_gpr1, gpr_wr.ld_gpr2, gpr_wr.ld_gpr3, ld_seg, ld_mm,
                ld_flags, ld_eip, ld_cs, dcache_wr.write};
      compare_value("enables", 64'(got_en), 64'(e.exp_en));
      compare_value("dep", 64'({dep.gpr1, dep.gpr2, dep.gpr3, dep.seg, dep.mm,
                    dep.dcache_write}), 64'({e.exp_en[8:4], e.exp_en[0]}));
      compare_value("halt_all", 64'(halt_all), 64'(e.exp_halt));
      compare_value("repne_terminate", 64'(repne_terminate), 64'(e.exp_term));
      compare_value("stall", 64'(stall), 64'(exp_stall));
      compare_value("final_flags", 64'(final_flags), 64'(e.exp_flags));
      compare_value("flags_fwd", 64'(flags_fwd), 64'(e.exp_fwd));
      compare_value("gpr data1", 64'(gpr_wr.data1), 64'(e.exp_data1));
      compare_value("gpr data2", 64'(gpr_wr.data2), 64'(e.result_b));
      compare_value("gpr data3", 64'(gpr_wr.data3), 64'(e.result_c));
      compare_value("gpr dr", 64'({gpr_wr.dr1, gpr_wr.dr2, gpr_wr.dr3}), 64'(e.dr));
      compare_value("datasize", 64'(gpr_wr.datasize), 64'(e.datasize));
      compare_value("final_eip", 64'(final_eip), 64'(e.exp_eip));
      compare_value("final_cs", 64'(final_cs), 64'(e.exp_cs));
      compare_value("count_fwd", 64'(count_fwd), 64'(e.exp_count));
      compare_value("mm_data", mm_data, e.result_mm);
      compare_value("dcache data", dcache_wr.data, e.exp_dc_data);
      compare_value("dcache addr", 64'(dcache_wr.addr), 64'(e.address));
   endtask

   task automatic wait_stall_release();
      int waited;
      waited = 0;
      while (stall !== 1'b0 && waited < 8) begin
         #0.5;
         waited++;
      end
      if (stall !== 1'b0) begin
         $display("timeout: stall stayed high after write_ready was raised");
         timed_out = 1'b1;
      end
   endtask

   task automatic apply_entry(input entry_t e);
      int held;
      held = 0;
      @(negedge CLK);
      wb_v            = e.wb_v;
      wb_ctrl         = e.ctrl;
      datasize        = e.datasize;
      ex_ld_gpr1      = e.ex_ld_gpr1;
      ex_ld_gpr2      = e.ex_ld_gpr2;
      ex_dcache_write = e.ex_dcache_write;
      repne           = e.repne;
      neip            = e.neip;
      ncs             = e.ncs;
      result_a        = e.result_a;
      result_b        = e.result_b;
      result_c        = e.result_c;
      flags_in        = e.flags_in;
      result_mm       = e.result_mm;
      {dr1, dr2, dr3} = e.dr;
      address         = e.address;
      write_ready     = (e.hold == 0);
      // upstream keeps the same uop while the port is busy
      while (held < e.hold) begin
         #1;
         check_outputs(e, e.wb_v & e.ex_dcache_write);
         @(negedge CLK);
         held++;
      end
      write_ready = 1'b1;
      #1;
      wait_stall_release();
      if (!timed_out) begin
         check_outputs(e, 1'b0);
      end
   endtask

   initial begin
      int errors_before;
      CLK             = 1'b0;
      rst_n           = 1'b0;
      wb_v            = 1'b0;
      wb_ctrl         = '0;
      datasize        = '0;
      ex_ld_gpr1      = 1'b0;
      ex_ld_gpr2      = 1'b0;
      ex_dcache_write = 1'b0;
      repne           = 1'b0;
      neip            = '0;
      ncs             = '0;
      result_a        = '0;
      result_b        = '0;
      result_c        = '0;
      flags_in        = '0;
      result_mm       = '0;
      dr1             = '0;
      dr2             = '0;
      dr3             = '0;
      address         = '0;
      write_ready     = 1'b1;
      error_count     = 0;
      pass_count      = 0;
      fail_count      = 0;
      timed_out       = 1'b0;
      lfsr_state      = 32'd33;
      flags_now       = FLAGS_RESET;
      build_table();
      repeat (2) @(posedge CLK);
      @(negedge CLK);
      rst_n = 1'b1;
      for (int i = 0; i < tests.size(); i++) begin
         errors_before = error_count;
         apply_entry(tests[i]);
         if (error_count == errors_before && !timed_out) begin
            pass_count++;
            $display("test %0d %s: ok", i + 1, tests[i].name);
         end else begin
            fail_count++;
            $display("test %0d %s: FAILED", i + 1, tests[i].name);
         end
         if (timed_out) begin
            break;
         end
      end
      $display("summary: %0d tests passed, %0d failed, %0d mismatches",
               pass_count, fail_count, error_count);
      if (fail_count == 0 && error_count == 0 && !timed_out) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* writeback.f */
hdl/wb_pkg.sv
hdl/flags_wb.sv
hdl/operand_select_wb.sv
hdl/branch_cond_wb.sv
hdl/repne_halt_wb.sv
hdl/validate_signals_wb.sv
hdl/writeback.sv
testbench/writeback_sva.sv
testbench/writeback_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module writeback_tb -f writeback.f \
   -o writeback_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/writeback_sim > sim.log 2>&1
cat sim.log
grep -qx "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
